// File: asic_macro.f
rtl/ml_pkg.sv
rtl/pad_sync.sv
rtl/ml_ctrl.sv
rtl/ml_tx.sv
rtl/ml_rx.sv
rtl/asic_macro.sv
sim/ml_mem_model.sv
sim/tb_asic_macro.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_asic_macro
FILELIST  ?= asic_macro.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_asic_macro.sv
`timescale 1ns/1ps

module tb_asic_macro;
    import ml_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DLY     = 5;
    localparam int RESET_CYCLES  = 10;
    localparam int N_OPS         = 40;
    localparam int N_ADDR        = 8;
    localparam int OP_CYCLES     = 30;
    localparam int MARGIN_CYCLES = 1000;
    localparam int DONE_LIMIT    = 60;
    localparam int WRITE_LAT     = 7;
    localparam int IRQ_LAT       = 2;
    localparam int IRQ_STEPS     = 16;

    logic        clk;
    logic        rst_n;
    logic        clko;
    logic [26:0] io_in;
    logic [26:0] io_out;
    logic [26:0] io_oeb;
    logic        req_valid;
    ml_req_t     req;
    logic        busy;
    logic        done;
    logic [31:0] rdata;
    logic [2:0]  irq;
    logic [2:0]  irq_pin;
    ml_req_t     wr_seen;
    int          wr_count;

    integer            seed;
    int                errors;
    int                checks;
    int                tests;
    int                pad_cycles;
    logic [ADDR_W-1:0] addr_pool [N_ADDR];
    // Reference memory, holds only what the testbench has written
    logic [DATA_W-1:0] ref_mem [bit [ADDR_W-1:0]];

    asic_macro dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .clko      (clko),
        .io_in     (io_in),
        .io_out    (io_out),
        .io_oeb    (io_oeb),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .irq       (irq)
    );

    ml_mem_model u_mem (
        .clko     (clko),
        .io_out   (io_out),
        .io_oeb   (io_oeb),
        .irq_pin  (irq_pin),
        .io_in    (io_in),
        .wr_seen  (wr_seen),
        .wr_count (wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_req(input string name, input ml_req_t got, input ml_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pads(input string name, input logic [26:0] got,
                              input logic [26:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Data pads are on exactly while abr is high, pads 26..23 are always inputs
    function automatic logic [26:0] expected_oeb(input logic abr);
        return {4'b1111, 1'b0, {ML_W{~abr}}};
    endfunction

    always @(negedge clk) begin
        pad_cycles++;
        check_pads("io_oeb", io_oeb, expected_oeb(io_out[22]));
    end

    // Checked in the middle of a reset cycle
    task automatic check_reset();
        int errs_before;
        errs_before = errors;
        check_word("busy", 32'(busy), 32'd0);
        check_word("done", 32'(done), 32'd0);
        check_word("abr", 32'(io_out[22]), 32'd0);
        check_word("clko", 32'(clko), 32'd0);
        check_pads("io_oeb", io_oeb, expected_oeb(1'b0));
        tests++;
        $display("reset state: %s", (errors == errs_before) ? "ok" : "error");
    endtask

    // Starts a posedge plus DRIVE_DLY and returns at the same point after done
    task automatic run_op(input int idx, input ml_req_t r);
        int                n;
        int                errs_before;
        int                wr_before;
        logic [DATA_W-1:0] exp;
        errs_before = errors;
        wr_before   = wr_count;
        req         = r;
        req_valid   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && (n < DONE_LIMIT));
        if (!done) begin
            errors++;
            $display("op %0d: no done pulse within %0d cycles", idx, DONE_LIMIT);
        end else if (r.write) begin
            check_word("write latency", 32'(n), 32'(WRITE_LAT));
            check_word("wr_count", 32'(wr_count), 32'(wr_before + 1));
            check_req("decoded write", wr_seen, r);
            ref_mem[r.addr] = r.wdata;
        end else begin
            exp = ref_mem.exists(r.addr) ? ref_mem[r.addr] : '0;
            check_word("rdata", rdata, exp);
        end
        tests++;
        $display("op %0d %s addr %05h: %s", idx, r.write ? "write" : "read", r.addr,
                 (errors == errs_before) ? "ok" : "error");
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Each new pin value must hold its old irq for one cycle and show on the second
    task automatic irq_test();
        logic [2:0] prev;
        int         errs_before;
        errs_before = errors;
        for (int i = 0; i < IRQ_STEPS; i++) begin
            prev    = irq_pin;
            irq_pin = 3'($random(seed));
            for (int c = 1; c <= IRQ_LAT; c++) begin
                @(posedge clk);
                @(negedge clk);
                check_word("irq", 32'(irq), (c < IRQ_LAT) ? 32'(prev) : 32'(irq_pin));
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        tests++;
        $display("interrupts: %s", (errors == errs_before) ? "ok" : "error");
    endtask

    initial begin
        ml_req_t op;
        seed       = 5;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        pad_cycles = 0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        irq_pin    = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_reset();
        @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        for (int i = 0; i < N_ADDR; i++) begin
            addr_pool[i] = ADDR_W'($random(seed));
        end
        for (int i = 0; i < N_OPS; i++) begin
            op.write = 1'($random(seed));
            op.addr  = addr_pool[$unsigned($random(seed)) % N_ADDR];
            op.wdata = $random(seed);
            run_op(i, op);
        end
        irq_test();
        tests++;
        $display("pad direction: %0d cycles watched", pad_cycles);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Budget covers the operations with room for reset, interrupts and slow reads
    initial begin
        #((N_OPS * OP_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d ns",
                 (N_OPS * OP_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: sim/ml_mem_model.sv
`timescale 1ns/1ps

module ml_mem_model (
    input  logic            clko,
    input  logic [26:0]     io_out,
    input  logic [26:0]     io_oeb,
    input  logic [2:0]      irq_pin,
    output logic [26:0]     io_in,
    output ml_pkg::ml_req_t wr_seen,
    output int              wr_count
);
    import ml_pkg::*;

    // B side changes its pins this long after the start of a link period
    localparam int DRIVE_DLY = 5;
    // Read answers start 2 to 9 link periods after the header
    localparam int GAP_MIN  = 2;
    localparam int GAP_SPAN = 8;

    logic [DATA_W-1:0] mem [bit [ADDR_W-1:0]];
    integer            seed;
    logic              bbr;
    logic [ML_W-1:0]   rd_pins;

    // Interrupts on 26..24, bbr on 23, the abr pad reads back as zero
    assign io_in = {irq_pin, bbr, 1'b0, rd_pins};

    // Waits for a rising link clock edge while A owns the link and its pins are on
    task automatic take_beat(output ml_beat_u b);
        do begin
            @(posedge clko);
        end while (!(io_out[22] && (io_oeb[ML_W-1:0] == '0)));
        b = io_out[ML_W-1:0];
    endtask

    // One beat lasts a full link period, starting just after the falling edge
    task automatic drive_beat(input logic own, input logic [ML_W-1:0] d);
        @(negedge clko);
        #DRIVE_DLY;
        bbr     = own;
        rd_pins = d;
    endtask

    initial begin
        ml_beat_u          hdr;
        ml_beat_u          lo;
        ml_beat_u          hi;
        logic [DATA_W-1:0] word;
        int                gap;
        seed     = 5;
        bbr      = 1'b0;
        rd_pins  = '0;
        wr_seen  = '0;
        wr_count = 0;
        forever begin
            take_beat(hdr);
            if (hdr.hdr.cmd == WRITE) begin
                take_beat(lo);
                take_beat(hi);
                word = {hi.data[DATA_W-ML_W-1:0], lo.data};
                mem[hdr.hdr.addr] = word;
                wr_seen.write = 1'b1;
                wr_seen.addr  = hdr.hdr.addr;
                wr_seen.wdata = word;
                wr_count++;
            end else if (hdr.hdr.cmd == READ) begin
                // Unwritten locations come back as zero
                word = mem.exists(hdr.hdr.addr) ? mem[hdr.hdr.addr] : '0;
                gap = GAP_MIN + int'($unsigned($random(seed)) % GAP_SPAN);
                repeat (gap - 1) @(negedge clko);
                drive_beat(1'b1, word[ML_W-1:0]);
                drive_beat(1'b1, ML_W'(word[DATA_W-1:ML_W]));
                // Let go of the bus after the second beat
                drive_beat(1'b0, '0);
            end
        end
    end

endmodule

// File: rtl/asic_macro.sv
`timescale 1ns/1ps

module asic_macro (
    input  logic            clk,
    input  logic            rst_n,
    output logic            clko,
    input  logic [26:0]     io_in,
    output logic [26:0]     io_out,
    output logic [26:0]     io_oeb,
    input  logic            req_valid,
    input  ml_pkg::ml_req_t req,
    output logic            busy,
    output logic            done,
    output logic [31:0]     rdata,
    output logic [2:0]      irq
);
    import ml_pkg::*;

    logic        drive_en;
    logic        load;
    logic        arm;
    logic        beat_last;
    logic        word_ok;
    logic        phase;
    logic        ml_clk;
    logic        bbr_s;
    logic [25:0] pin_s;
    ml_beat_u    tx_beat;
    ml_beat_u    rx_beat;

    // All pad inputs share one synchronizer, the data pins are
    // captured even while A is driving and simply ignored then
    pad_sync u_sync (
        .clk   (clk),
        .rst_n (rst_n),
        .pin   ({io_in[26:23], io_in[ML_W-1:0]}),
        .pin_s (pin_s)
    );

    assign rx_beat = pin_s[ML_W-1:0];
    assign bbr_s   = pin_s[22];
    assign irq     = pin_s[25:23];

    ml_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .beat_last (beat_last),
        .word_ok   (word_ok),
        .load      (load),
        .drive_en  (drive_en),
        .arm       (arm),
        .busy      (busy),
        .done      (done)
    );

    ml_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .req       (req),
        .ml_clk    (ml_clk),
        .phase     (phase),
        .beat      (tx_beat),
        .beat_last (beat_last)
    );

    ml_rx u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .arm     (arm),
        .phase   (phase),
        .bbr_s   (bbr_s),
        .data_s  (rx_beat),
        .word_ok (word_ok),
        .rdata   (rdata)
    );

    assign clko = ml_clk;

    // Link data pins, output enables active low follow bus ownership
    assign io_out[ML_W-1:0] = tx_beat;
    assign io_oeb[ML_W-1:0] = {ML_W{~drive_en}};

    // abr tells B that A holds the link, always driven
    assign io_out[22] = drive_en;
    assign io_oeb[22] = 1'b0;

    // bbr and the three interrupt pins are inputs only
    assign io_out[26:23] = 4'd0;
    assign io_oeb[26:23] = 4'b1111;

endmodule

// File: rtl/ml_rx.sv
`timescale 1ns/1ps

module ml_rx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              arm,
    input  logic              phase,
    input  logic              bbr_s,
    input  ml_pkg::ml_beat_u  data_s,
    output logic              word_ok,
    output logic [31:0]       rdata
);
    import ml_pkg::*;

    logic [SYNC_STAGES-1:0] phase_d;
    logic                   armed;
    logic [1:0]             beat_idx;
    logic [ML_W-1:0]        lo_q;
    logic                   take;
    logic                   take_last;

    // The pad inputs arrive SYNC_STAGES cycles late, so the phase
    // goes through an equal delay to stay lined up with them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_d <= '0;
        end else begin
            phase_d <= {phase_d[SYNC_STAGES-2:0], phase};
        end
    end

    // One sample per link period, only while B owns the bus
    assign take      = armed && bbr_s && phase_d[SYNC_STAGES-1];
    assign take_last = take && (beat_idx == 2'(ML_DATA_BEATS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b0;
            beat_idx <= 2'd0;
            word_ok  <= 1'b0;
        end else begin
            word_ok <= take_last;
            if (arm) begin
                armed    <= 1'b1;
                beat_idx <= 2'd0;
            end else if (take_last) begin
                armed    <= 1'b0;
                beat_idx <= 2'd0;
            end else if (take) begin
                beat_idx <= beat_idx + 2'd1;
            end
        end
    end

    // First beat is parked so rdata only moves when the word is whole
    always_ff @(posedge clk) begin
        if (take && !take_last) begin
            lo_q <= data_s.data;
        end
        if (take_last) begin
            rdata <= {data_s.data[DATA_W-ML_W-1:0], lo_q};
        end
    end

endmodule

// File: rtl/ml_tx.sv
`timescale 1ns/1ps

module ml_tx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  ml_pkg::ml_req_t  req,
    output logic             ml_clk,
    output logic             phase,
    output ml_pkg::ml_beat_u beat,
    output logic             beat_last
);
    import ml_pkg::*;

    ml_req_t    req_q;
    logic       active;
    logic [1:0] beat_idx;
    logic [1:0] last_idx;

    // A read frame is only the header, a write adds the data beats
    assign last_idx = req_q.write ? 2'(ML_DATA_BEATS) : 2'd0;

    // Phase toggles every clk, and a load restarts it low so the
    // header gets a full period right after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (load) begin
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
        end
    end

    // Link clock is the phase itself, B samples on its rising edge
    assign ml_clk = phase;

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= req;
        end
    end

    // Step to the next beat at the end of each high phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            beat_idx <= 2'd0;
        end else if (load) begin
            active   <= 1'b1;
            beat_idx <= 2'd0;
        end else if (active && phase) begin
            if (beat_idx == last_idx) begin
                active   <= 1'b0;
                beat_idx <= 2'd0;
            end else begin
                beat_idx <= beat_idx + 2'd1;
            end
        end
    end

    assign beat_last = active && phase && (beat_idx == last_idx);

    // Beat 0 is the header view, then low and high data slices
    // Idle output reads as a NOP header at address zero
    always_comb begin
        beat.data = '0;
        if (active) begin
            case (beat_idx)
                2'd0: begin
                    beat.hdr.cmd  = req_q.write ? WRITE : READ;
                    beat.hdr.addr = req_q.addr;
                end
                2'd1: begin
                    beat.data = req_q.wdata[ML_W-1:0];
                end
                default: begin
                    beat.data = ML_W'(req_q.wdata[DATA_W-1:ML_W]);
                end
            endcase
        end
    end

    // A new frame must never cut into the one still on the pins
    a_load_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) load |-> !active
    );

endmodule

// File: rtl/ml_ctrl.sv
`timescale 1ns/1ps

module ml_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_valid,
    input  ml_pkg::ml_req_t req,
    input  logic            beat_last,
    input  logic            word_ok,
    output logic            load,
    output logic            drive_en,
    output logic            arm,
    output logic            busy,
    output logic            done
);
    import ml_pkg::*;

    ml_state_e state;
    ml_state_e state_nxt;
    logic      is_write;

    // A request is taken only from IDLE and anything else is dropped
    assign load = req_valid && (state == IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                // Writes finish with the last data beat
                // Reads give up the link after the header
                if (beat_last) begin
                    state_nxt = is_write ? DONE : TURN;
                end
            end
            TURN: begin
                // Single dead cycle so both sides are off the pins
                state_nxt = RECV;
            end
            RECV: begin
                if (word_ok) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Remember the kind of frame for the SEND exit decision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_write <= 1'b0;
        end else if (load) begin
            is_write <= req.write;
        end
    end

    // Bus ownership comes from a flop so abr and the pad enables
    // switch cleanly and stay high for exactly the SEND cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drive_en <= 1'b0;
        end else begin
            drive_en <= (state_nxt == SEND);
        end
    end

    // Receiver is armed once at the start of the turnaround
    assign arm  = (state == TURN);
    assign busy = (state != IDLE);
    assign done = (state == DONE);

    // The core may only strobe a request while the link is idle
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) req_valid |-> !busy
    );

    // The final beat of a frame must still leave while A holds the link
    a_last_beat_driven: assert property (
        @(posedge clk) disable iff (!rst_n) beat_last |-> drive_en
    );

endmodule

// File: rtl/pad_sync.sv
`timescale 1ns/1ps

module pad_sync (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [25:0] pin,
    output logic [25:0] pin_s
);
    import ml_pkg::*;

    // Stage 0 takes the raw pins, the last stage feeds the core
    // Bits are link data 21..0, bbr at 22 and interrupts at 25..23
    logic [SYNC_STAGES-1:0][25:0] sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], pin};
        end
    end

    assign pin_s = sync_q[SYNC_STAGES-1];

endmodule

// File: rtl/ml_pkg.sv
package ml_pkg;

    // Width of one beat on the memory link pads
    localparam int ML_W = 22;
    // Word address carried in a header beat
    localparam int ADDR_W = 20;
    // Data word moved by a single request
    localparam int DATA_W = 32;
    // Depth of the flop chain on every pad input
    localparam int SYNC_STAGES = 2;
    // A 32-bit word needs two 22-bit beats on the link
    localparam int ML_DATA_BEATS = 2;

    // Command field in the header beat
    // NOP is what an idle A side presents on the data pins
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } ml_cmd_e;

    // Header view of a beat, command in the top two bits
    typedef struct packed {
        ml_cmd_e           cmd;
        logic [ADDR_W-1:0] addr;
    } ml_hdr_t;

    // The same 22 pins are read as a header on the first beat of a frame
    // and as raw data bits on the beats that follow
    // Second data beat holds word bits 31..22 in its low 10 bits
    typedef union packed {
        ml_hdr_t         hdr;
        logic [ML_W-1:0] data;
    } ml_beat_u;

    // Core side request, wdata is ignored for reads
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } ml_req_t;

    // Link controller states
    typedef enum logic [2:0] {
        IDLE,
        SEND,
        TURN,
        RECV,
        DONE
    } ml_state_e;

endpackage
